// File: design/bomb_audio_pkg.sv
`default_nettype none

package bomb_audio_pkg;

  // clock cycles between two buzzer edges
  typedef logic [15:0] half_t;

  // buzzer edges per sound
  // must be even so the line ends low
  typedef logic [8:0] toggles_t;

  // minutes digit
  typedef logic [2:0] min_t;

  // tens of seconds, 0..5
  typedef logic [2:0] tens_t;

  // seconds, 0..9
  typedef logic [3:0] ones_t;

  // tick rate as the clock runs down
  // normal above 0:39, fast down to 0:20, faster below
  typedef enum logic [1:0] {
    pace_normal,
    pace_fast,
    pace_faster
  } pace_e;

endpackage

`default_nettype wire

// File: design/tone_if.sv
`default_nettype none
`timescale 1ns/100ps

interface tone_if;

  // one-cycle start, restarts a playing voice
  logic                     trigger;
  // tone settings, held static by the controller
  bomb_audio_pkg::half_t    half_period;
  bomb_audio_pkg::toggles_t toggles;
  // voice status and square wave
  logic                     busy;
  logic                     wave;

  // sound controller side
  modport ctrl (
    output trigger, half_period, toggles,
    input  busy, wave
  );

  // tone generator side
  modport voice (
    input  trigger, half_period, toggles,
    output busy, wave
  );

endinterface

`default_nettype wire

// File: design/tone_voice.sv
`default_nettype none
`timescale 1ns/100ps

module tone_voice (
  input logic   clk,
  input logic   nrst,
  tone_if.voice voice
);

  typedef enum logic {
    voice_idle,
    voice_play
  } voice_state_e;

  voice_state_e             state;
  // cycles since the last edge, 1-based
  bomb_audio_pkg::half_t    half_cnt;
  // edges made so far
  bomb_audio_pkg::toggles_t tog_cnt;
  logic                     edge_due;
  logic                     last_edge;

  // half period elapsed
  assign edge_due = (half_cnt == voice.half_period);

  // this edge brings the line back low for good
  assign last_edge = (tog_cnt == bomb_audio_pkg::toggles_t'(voice.toggles - 1'b1));

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      state      <= voice_idle;
      half_cnt   <= '0;
      tog_cnt    <= '0;
      voice.wave <= 1'b0;
    end else if (voice.trigger) begin
      // start, or start over from the top
      state      <= voice_play;
      half_cnt   <= 16'd1;
      tog_cnt    <= '0;
      voice.wave <= 1'b0;
    end else if (state == voice_play) begin
      if (edge_due) begin
        half_cnt <= 16'd1;
        tog_cnt  <= tog_cnt + 1'b1;
        if (last_edge) begin
          // busy drops together with the final falling edge
          state      <= voice_idle;
          voice.wave <= 1'b0;
        end else begin
          voice.wave <= ~voice.wave;
        end
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  assign voice.busy = (state == voice_play);

  // a voice only starts on request from the controller
  assert property (@(posedge clk) disable iff (!nrst)
    $rose(voice.busy) |-> $past(voice.trigger))
    else $error("tone voice started without a trigger");

  // idle voice keeps its line quiet
  assert property (@(posedge clk) disable iff (!nrst)
    !voice.busy |-> !voice.wave)
    else $error("tone voice wave high while idle");

endmodule

`default_nettype wire

// File: design/countdown_timer.sv
`default_nettype none
`timescale 1ns/100ps

module countdown_timer #(
  parameter int                    CLKS_PER_SEC = 10_000_000,
  parameter bomb_audio_pkg::min_t  START_MIN    = 3'd2,
  parameter bomb_audio_pkg::tens_t START_TENS   = 3'd0,
  parameter bomb_audio_pkg::ones_t START_ONES   = 4'd0
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  game_start,
  input  logic                  game_clear,
  output bomb_audio_pkg::min_t  cnt_min,
  output bomb_audio_pkg::tens_t cnt_sec_ten,
  output bomb_audio_pkg::ones_t cnt_sec_one,
  output logic                  running,
  output logic                  exploded,
  output logic                  detonate,
  output bomb_audio_pkg::pace_e pace,
  output logic                  tick_sec,
  output logic                  tick_half,
  output logic                  tick_quarter
);

  localparam int DIV_W   = $clog2(CLKS_PER_SEC);
  localparam int HALF    = CLKS_PER_SEC / 2;
  localparam int QUARTER = CLKS_PER_SEC / 4;

  // cycle position inside the current second
  logic [DIV_W-1:0] div;
  logic             sec_end;
  logic             last_sec;

  assign sec_end = running && (div == DIV_W'(CLKS_PER_SEC - 1));

  // 0:01 showing, next decrement hits zero
  assign last_sec = (cnt_min == '0) && (cnt_sec_ten == '0) && (cnt_sec_one == 4'd1);

  // strobes, all landing on the second boundary
  assign tick_sec  = sec_end;
  assign tick_half = running &&
                     ((div == DIV_W'(HALF - 1)) || (div == DIV_W'(CLKS_PER_SEC - 1)));
  assign tick_quarter = running &&
                        ((div == DIV_W'(QUARTER - 1)) ||
                         (div == DIV_W'(HALF - 1)) ||
                         (div == DIV_W'(HALF + QUARTER - 1)) ||
                         (div == DIV_W'(CLKS_PER_SEC - 1)));

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      div         <= '0;
      cnt_min     <= '0;
      cnt_sec_ten <= '0;
      cnt_sec_one <= '0;
      running     <= 1'b0;
      exploded    <= 1'b0;
      detonate    <= 1'b0;
    end else begin
      // single-cycle pulse
      detonate <= 1'b0;
      if (game_start) begin
        div         <= '0;
        cnt_min     <= START_MIN;
        cnt_sec_ten <= START_TENS;
        cnt_sec_one <= START_ONES;
        running     <= 1'b1;
        exploded    <= 1'b0;
      end else if (game_clear) begin
        // defused, digits stay where they are
        running <= 1'b0;
        div     <= '0;
      end else if (running) begin
        if (sec_end) begin
          div <= '0;
          if (last_sec) begin
            cnt_sec_one <= '0;
            running     <= 1'b0;
            exploded    <= 1'b1;
            detonate    <= 1'b1;
          end else if (cnt_sec_one != '0) begin
            cnt_sec_one <= cnt_sec_one - 1'b1;
          end else begin
            // borrow from tens, then minutes
            cnt_sec_one <= 4'd9;
            if (cnt_sec_ten != '0) begin
              cnt_sec_ten <= cnt_sec_ten - 1'b1;
            end else begin
              cnt_sec_ten <= 3'd5;
              cnt_min     <= cnt_min - 1'b1;
            end
          end
        end else begin
          div <= div + 1'b1;
        end
      end
    end
  end

  // faster under 0:20, fast under 0:40
  always_comb begin
    if ((cnt_min == '0) && (cnt_sec_ten <= 3'd1)) begin
      pace = bomb_audio_pkg::pace_faster;
    end else if ((cnt_min == '0) && (cnt_sec_ten <= 3'd3)) begin
      pace = bomb_audio_pkg::pace_fast;
    end else begin
      pace = bomb_audio_pkg::pace_normal;
    end
  end

  // digits stay decimal through every borrow
  assert property (@(posedge clk) disable iff (!nrst)
    cnt_sec_one <= 4'd9)
    else $error("seconds digit out of range");

  assert property (@(posedge clk) disable iff (!nrst)
    cnt_sec_ten <= 3'd5)
    else $error("tens digit out of range");

endmodule

`default_nettype wire

// File: design/audio_sm.sv
`default_nettype none
`timescale 1ns/100ps

module audio_sm #(
  parameter bomb_audio_pkg::half_t    ERR_HALF      = 16'd48000,
  parameter bomb_audio_pkg::toggles_t ERR_TOGGLES   = 9'd100,
  parameter bomb_audio_pkg::half_t    BOOM_HALF     = 16'd60000,
  parameter bomb_audio_pkg::toggles_t BOOM_TOGGLES  = 9'd400,
  parameter bomb_audio_pkg::half_t    CHIME_HALF    = 16'd20000,
  parameter bomb_audio_pkg::toggles_t CHIME_TOGGLES = 9'd100,
  parameter bomb_audio_pkg::half_t    TICK_HALF     = 16'd15000,
  parameter bomb_audio_pkg::toggles_t TICK_TOGGLES  = 9'd100
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  error,
  input  logic                  module_solved,
  input  logic                  detonate,
  input  logic                  running,
  input  bomb_audio_pkg::pace_e pace,
  input  logic                  tick_sec,
  input  logic                  tick_half,
  input  logic                  tick_quarter,
  output logic                  audio
);

  // one voice per sound, highest priority first
  tone_if err_if ();
  tone_if boom_if ();
  tone_if chime_if ();
  tone_if tick_if ();

  // module_solved, one cycle late
  logic solved_q;
  // tick strobe for the current pace
  logic tick_strobe;

  // fixed tone settings
  assign err_if.half_period   = ERR_HALF;
  assign err_if.toggles       = ERR_TOGGLES;
  assign boom_if.half_period  = BOOM_HALF;
  assign boom_if.toggles      = BOOM_TOGGLES;
  assign chime_if.half_period = CHIME_HALF;
  assign chime_if.toggles     = CHIME_TOGGLES;
  assign tick_if.half_period  = TICK_HALF;
  assign tick_if.toggles      = TICK_TOGGLES;

  // more ticks per second as time runs out
  always_comb begin
    case (pace)
      bomb_audio_pkg::pace_faster: tick_strobe = tick_quarter;
      bomb_audio_pkg::pace_fast:   tick_strobe = tick_half;
      default:                     tick_strobe = tick_sec;
    endcase
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      solved_q         <= 1'b0;
      err_if.trigger   <= 1'b0;
      boom_if.trigger  <= 1'b0;
      chime_if.trigger <= 1'b0;
      tick_if.trigger  <= 1'b0;
      audio            <= 1'b0;
    end else begin
      solved_q <= module_solved;
      // triggers one cycle behind their cause
      err_if.trigger   <= error;
      boom_if.trigger  <= detonate;
      // chime once per solve, however long it is held
      chime_if.trigger <= module_solved && !solved_q;
      // no ticking once the clock has stopped
      tick_if.trigger  <= running && tick_strobe;
      // fixed priority mux, error buzz on top
      if (err_if.busy) begin
        audio <= err_if.wave;
      end else if (boom_if.busy) begin
        audio <= boom_if.wave;
      end else if (chime_if.busy) begin
        audio <= chime_if.wave;
      end else if (tick_if.busy) begin
        audio <= tick_if.wave;
      end else begin
        audio <= 1'b0;
      end
    end
  end

  tone_voice u_err_voice (
    .clk   (clk),
    .nrst  (nrst),
    .voice (err_if.voice)
  );

  tone_voice u_boom_voice (
    .clk   (clk),
    .nrst  (nrst),
    .voice (boom_if.voice)
  );

  tone_voice u_chime_voice (
    .clk   (clk),
    .nrst  (nrst),
    .voice (chime_if.voice)
  );

  tone_voice u_tick_voice (
    .clk   (clk),
    .nrst  (nrst),
    .voice (tick_if.voice)
  );

  // at the fastest pace, the last tick has ended before the next quarter strobe
  assert property (@(posedge clk) disable iff (!nrst)
    (running && (pace == bomb_audio_pkg::pace_faster) && tick_quarter) |-> !tick_if.busy)
    else $error("tick sound longer than a quarter second");

endmodule

`default_nettype wire

// File: design/bomb_audio_top.sv
`default_nettype none
`timescale 1ns/100ps

module bomb_audio_top #(
  // game clock
  parameter int                       CLKS_PER_SEC  = 10_000_000,
  parameter bomb_audio_pkg::min_t     START_MIN     = 3'd2,
  parameter bomb_audio_pkg::tens_t    START_TENS    = 3'd0,
  parameter bomb_audio_pkg::ones_t    START_ONES    = 4'd0,
  // sounds
  parameter bomb_audio_pkg::half_t    ERR_HALF      = 16'd48000,
  parameter bomb_audio_pkg::toggles_t ERR_TOGGLES   = 9'd100,
  parameter bomb_audio_pkg::half_t    BOOM_HALF     = 16'd60000,
  parameter bomb_audio_pkg::toggles_t BOOM_TOGGLES  = 9'd400,
  parameter bomb_audio_pkg::half_t    CHIME_HALF    = 16'd20000,
  parameter bomb_audio_pkg::toggles_t CHIME_TOGGLES = 9'd100,
  parameter bomb_audio_pkg::half_t    TICK_HALF     = 16'd15000,
  parameter bomb_audio_pkg::toggles_t TICK_TOGGLES  = 9'd100
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  game_start,
  input  logic                  game_clear,
  input  logic                  error,
  input  logic                  module_solved,
  output logic                  audio,
  output bomb_audio_pkg::min_t  cnt_min,
  output bomb_audio_pkg::tens_t cnt_sec_ten,
  output bomb_audio_pkg::ones_t cnt_sec_one,
  output logic                  running,
  output logic                  exploded
);

  // timer to sound controller
  logic                  detonate;
  logic                  tick_sec;
  logic                  tick_half;
  logic                  tick_quarter;
  bomb_audio_pkg::pace_e pace;

  countdown_timer #(
    .CLKS_PER_SEC (CLKS_PER_SEC),
    .START_MIN    (START_MIN),
    .START_TENS   (START_TENS),
    .START_ONES   (START_ONES)
  ) u_timer (
    .clk          (clk),
    .nrst         (nrst),
    .game_start   (game_start),
    .game_clear   (game_clear),
    .cnt_min      (cnt_min),
    .cnt_sec_ten  (cnt_sec_ten),
    .cnt_sec_one  (cnt_sec_one),
    .running      (running),
    .exploded     (exploded),
    .detonate     (detonate),
    .pace         (pace),
    .tick_sec     (tick_sec),
    .tick_half    (tick_half),
    .tick_quarter (tick_quarter)
  );

  audio_sm #(
    .ERR_HALF      (ERR_HALF),
    .ERR_TOGGLES   (ERR_TOGGLES),
    .BOOM_HALF     (BOOM_HALF),
    .BOOM_TOGGLES  (BOOM_TOGGLES),
    .CHIME_HALF    (CHIME_HALF),
    .CHIME_TOGGLES (CHIME_TOGGLES),
    .TICK_HALF     (TICK_HALF),
    .TICK_TOGGLES  (TICK_TOGGLES)
  ) u_audio (
    .clk           (clk),
    .nrst          (nrst),
    .error         (error),
    .module_solved (module_solved),
    .detonate      (detonate),
    .running       (running),
    .pace          (pace),
    .tick_sec      (tick_sec),
    .tick_half     (tick_half),
    .tick_quarter  (tick_quarter),
    .audio         (audio)
  );

endmodule

`default_nettype wire

// File: bench/bomb_audio_tb.sv
`default_nettype none
`timescale 1ns/100ps

module bomb_audio_tb;

  // small game with 400 cycles per second and a 0:42 start
  localparam int CLKS_PER_SEC  = 400;
  localparam int START_MIN     = 0;
  localparam int START_TENS    = 4;
  localparam int START_ONES    = 2;
  localparam int ERR_HALF      = 3;
  localparam int ERR_TOGGLES   = 6;
  localparam int BOOM_HALF     = 5;
  localparam int BOOM_TOGGLES  = 8;
  localparam int CHIME_HALF    = 4;
  localparam int CHIME_TOGGLES = 4;
  localparam int TICK_HALF     = 2;
  localparam int TICK_TOGGLES  = 2;
  // longest sound plus trigger and output latency
  localparam int SETTLE        = 64;

  // row actions
  localparam int ACT_LISTEN     = 0;
  localparam int ACT_ERROR      = 1;
  localparam int ACT_SOLVED     = 2;
  localparam int ACT_ERR_CHIME  = 3;
  localparam int ACT_START      = 4;
  localparam int ACT_SECONDS    = 5;
  localparam int ACT_CLEAR      = 6;

  logic                  clk;
  logic                  nrst;
  logic                  game_start;
  logic                  game_clear;
  logic                  error;
  logic                  module_solved;
  logic                  audio;
  bomb_audio_pkg::min_t  cnt_min;
  bomb_audio_pkg::tens_t cnt_sec_ten;
  bomb_audio_pkg::ones_t cnt_sec_one;
  logic                  running;
  logic                  exploded;

  // stimulus table with one entry per row in each queue
  string row_name[$];
  int    row_act[$];
  int    row_n[$];
  int    row_pulses[$];
  int    row_width[$];
  int    row_min[$];
  int    row_ten[$];
  int    row_one[$];
  int    row_run[$];
  int    row_expl[$];

  // audio pulse monitor
  int run_len;
  int pulse_cnt;
  int width_min;
  int width_max;

  int n_checks;
  int n_errors;
  int cycles;
  int cycle_limit;

  // reference model of the game clock
  int  m_secs;
  bit  m_first;

  bomb_audio_top #(
    .CLKS_PER_SEC  (CLKS_PER_SEC),
    .START_MIN     (3'(START_MIN)),
    .START_TENS    (3'(START_TENS)),
    .START_ONES    (4'(START_ONES)),
    .ERR_HALF      (16'(ERR_HALF)),
    .ERR_TOGGLES   (9'(ERR_TOGGLES)),
    .BOOM_HALF     (16'(BOOM_HALF)),
    .BOOM_TOGGLES  (9'(BOOM_TOGGLES)),
    .CHIME_HALF    (16'(CHIME_HALF)),
    .CHIME_TOGGLES (9'(CHIME_TOGGLES)),
    .TICK_HALF     (16'(TICK_HALF)),
    .TICK_TOGGLES  (9'(TICK_TOGGLES))
  ) uut (
    .clk           (clk),
    .nrst          (nrst),
    .game_start    (game_start),
    .game_clear    (game_clear),
    .error         (error),
    .module_solved (module_solved),
    .audio         (audio),
    .cnt_min       (cnt_min),
    .cnt_sec_ten   (cnt_sec_ten),
    .cnt_sec_one   (cnt_sec_one),
    .running       (running),
    .exploded      (exploded)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // measure audio high pulses away from the driving edge
  always @(negedge clk) begin
    if (audio) begin
      run_len = run_len + 1;
    end else if (run_len > 0) begin
      pulse_cnt = pulse_cnt + 1;
      if (run_len < width_min) begin
        width_min = run_len;
      end
      if (run_len > width_max) begin
        width_max = run_len;
      end
      run_len = 0;
    end
  end

  // run length guard with a limit from the table
  always @(posedge clk) begin
    cycles = cycles + 1;
    if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("checks %0d, errors %0d", n_checks, n_errors + 1);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic add_row(input string name, input int act, input int n, input int pulses,
                         input int width, input int mn, input int ten, input int one,
                         input int run, input int expl);
    row_name.push_back(name);
    row_act.push_back(act);
    row_n.push_back(n);
    row_pulses.push_back(pulses);
    row_width.push_back(width);
    row_min.push_back(mn);
    row_ten.push_back(ten);
    row_one.push_back(one);
    row_run.push_back(run);
    row_expl.push_back(expl);
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    n_checks = n_checks + 1;
    if (expected != actual) begin
      n_errors = n_errors + 1;
      $display("error %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic clear_monitor();
    run_len   = 0;
    pulse_cnt = 0;
    width_min = 1 << 30;
    width_max = 0;
  endtask

  // every wait ends 1 ns after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_sound(input string name, input int pulses, input int width);
    check_value({name, " pulses"}, pulses, pulse_cnt);
    if ((pulses > 0) && (pulse_cnt > 0)) begin
      check_value({name, " shortest pulse"}, width, width_min);
      check_value({name, " longest pulse"}, width, width_max);
    end
  endtask

  // ticks per second from the pace rule
  function automatic int ticks_per_second(input int secs);
    int mn;
    int ten;
    mn  = secs / 60;
    ten = (secs % 60) / 10;
    if ((mn == 0) && (ten <= 1)) begin
      return 4;
    end else if ((mn == 0) && (ten <= 3)) begin
      return 2;
    end
    return 1;
  endfunction

  // one second from one digit change to the next
  task automatic run_second(input string name);
    int groups;
    int prev;
    int waited;
    groups = ticks_per_second(m_secs);
    // the first second after a start has no boundary tick from before
    if (m_first) begin
      groups = groups - 1;
    end
    m_first = 1'b0;
    m_secs  = m_secs - 1;
    waited  = 0;
    clear_monitor();
    prev = {cnt_min, cnt_sec_ten, cnt_sec_one};
    while ({cnt_min, cnt_sec_ten, cnt_sec_one} == prev) begin
      wait_cycles(1);
      waited = waited + 1;
    end
    check_value({name, " second length"}, CLKS_PER_SEC, waited);
    // each tick group is a short beep of its own
    check_sound(name, groups * (TICK_TOGGLES / 2), TICK_HALF);
    check_value({name, " seconds left"}, m_secs,
                cnt_min * 60 + cnt_sec_ten * 10 + cnt_sec_one);
    check_value({name, " running"}, (m_secs != 0), running);
  endtask

  initial begin : main_flow
    int i;
    nrst          = 1'b0;
    game_start    = 1'b0;
    game_clear    = 1'b0;
    error         = 1'b0;
    module_solved = 1'b0;
    n_checks      = 0;
    n_errors      = 0;
    cycles        = 0;
    m_secs        = 0;
    m_first       = 1'b0;
    clear_monitor();

    add_row("reset", ACT_LISTEN, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row("error_idle", ACT_ERROR, 0, ERR_TOGGLES / 2, ERR_HALF, 0, 0, 0, 0, 0);
    add_row("solved_held", ACT_SOLVED, 0, CHIME_TOGGLES / 2, CHIME_HALF, 0, 0, 0, 0, 0);
    add_row("error_over_chime", ACT_ERR_CHIME, 0, ERR_TOGGLES / 2, ERR_HALF,
            0, 0, 0, 0, 0);
    add_row("start", ACT_START, 0, 0, 0, START_MIN, START_TENS, START_ONES, 1, 0);
    add_row("countdown", ACT_SECONDS, 42, -1, 0, 0, 0, 0, 0, 1);
    add_row("boom", ACT_LISTEN, 0, BOOM_TOGGLES / 2, BOOM_HALF, 0, 0, 0, 0, 1);
    add_row("restart", ACT_START, 0, 0, 0, START_MIN, START_TENS, START_ONES, 1, 0);
    add_row("two_seconds", ACT_SECONDS, 2, -1, 0, 0, 4, 0, 1, 0);
    add_row("clear", ACT_CLEAR, 0, 0, 0, 0, 4, 0, 0, 0);

    // reset and every row's wait plus two seconds of margin
    cycle_limit = 8 + 2 * CLKS_PER_SEC;
    for (i = 0; i < row_name.size(); i++) begin
      if (row_act[i] == ACT_SECONDS) begin
        cycle_limit = cycle_limit + row_n[i] * CLKS_PER_SEC;
      end else if (row_act[i] == ACT_CLEAR) begin
        cycle_limit = cycle_limit + SETTLE + 3 * CLKS_PER_SEC;
      end else begin
        cycle_limit = cycle_limit + 2 * SETTLE + 4;
      end
    end

    repeat (8) @(posedge clk);
    #1;
    nrst = 1'b1;
    check_value("reset audio", 0, audio);

    for (i = 0; i < row_name.size(); i++) begin
      clear_monitor();
      case (row_act[i])
        ACT_ERROR: begin
          wait_cycles(1);
          error = 1'b1;
          wait_cycles(1);
          error = 1'b0;
          wait_cycles(SETTLE);
        end
        ACT_SOLVED: begin
          // a long hold still gives a single chime
          wait_cycles(1);
          module_solved = 1'b1;
          wait_cycles(SETTLE);
          module_solved = 1'b0;
          wait_cycles(SETTLE);
        end
        ACT_ERR_CHIME: begin
          wait_cycles(1);
          module_solved = 1'b1;
          wait_cycles(1);
          module_solved = 1'b0;
          // error lands after the first chime pulse
          while (!audio) begin
            wait_cycles(1);
          end
          while (audio) begin
            wait_cycles(1);
          end
          clear_monitor();
          wait_cycles(1);
          error = 1'b1;
          wait_cycles(1);
          error = 1'b0;
          wait_cycles(SETTLE);
        end
        ACT_START: begin
          wait_cycles(1);
          game_start = 1'b1;
          wait_cycles(1);
          game_start = 1'b0;
          m_secs  = START_MIN * 60 + START_TENS * 10 + START_ONES;
          m_first = 1'b1;
        end
        ACT_SECONDS: begin
          repeat (row_n[i]) run_second(row_name[i]);
        end
        ACT_CLEAR: begin
          wait_cycles(1);
          game_clear = 1'b1;
          wait_cycles(1);
          game_clear = 1'b0;
          // let the boundary tick that already started drain
          wait_cycles(SETTLE);
          clear_monitor();
          wait_cycles(2 * CLKS_PER_SEC);
        end
        default: begin
          wait_cycles(SETTLE);
        end
      endcase
      if (row_pulses[i] >= 0) begin
        check_sound(row_name[i], row_pulses[i], row_width[i]);
      end
      check_value({row_name[i], " minutes"}, row_min[i], cnt_min);
      check_value({row_name[i], " tens"}, row_ten[i], cnt_sec_ten);
      check_value({row_name[i], " ones"}, row_one[i], cnt_sec_one);
      check_value({row_name[i], " running"}, row_run[i], running);
      check_value({row_name[i], " exploded"}, row_expl[i], exploded);
    end

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
design/bomb_audio_pkg.sv
design/tone_if.sv
design/tone_voice.sv
design/countdown_timer.sv
design/audio_sm.sv
design/bomb_audio_top.sv
bench/bomb_audio_tb.sv

// File: Bender.yml
package:
  name: bomb_audio

sources:
  - design/bomb_audio_pkg.sv
  - design/tone_if.sv
  - design/tone_voice.sv
  - design/countdown_timer.sv
  - design/audio_sm.sv
  - design/bomb_audio_top.sv
  - target: test
    files:
      - bench/bomb_audio_tb.sv
